/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_conv
SIM_F     ?= sim.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FAIL_MSG  := Test failures found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(SIM_F)

sim:
	$(VERILATOR) --binary --assert -Wno-fatal --top-module $(TOP) -f $(SIM_F) \
	  --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* conv_asserts.sv */
`include "conv_defs.svh"
`default_nettype none

module conv_asserts (
  input wire                      clk,
  input wire                      xrst,
  input wire                      buf_en,
  input wire                      busy,
  input wire conv_pkg::lb_state_e state,
  input wire                      win_valid,
  input wire                      out_valid,
  input wire conv_pkg::pixel_t    out_data
);

  valid_low_in_reset: assert property (@(posedge clk) !xrst |=> !win_valid && !out_valid)
    else $error("valid still high after a reset cycle");

  valid_only_when_busy: assert property (@(posedge clk) disable iff (!xrst)
    win_valid |-> busy)
    else $error("window valid high while the line buffer is idle");

  // A strobe during a frame or its drain must not start a new charge.
  no_restart_while_busy: assert property (@(posedge clk) disable iff (!xrst)
    buf_en && busy && state != conv_pkg::S_CHARGE |=> state != conv_pkg::S_CHARGE)
    else $error("start strobe accepted while busy");

  output_not_negative: assert property (@(posedge clk) disable iff (!xrst)
    out_valid |-> !out_data[`DWIDTH-1])
    else $error("negative output data");

endmodule

bind conv_top conv_asserts u_conv_asserts (
  .clk       (clk),
  .xrst      (xrst),
  .buf_en    (buf_en),
  .busy      (busy),
  .state     (u_linebuf.r_state),
  .win_valid (win_valid),
  .out_valid (out_valid),
  .out_data  (out_data)
);

`default_nettype wire

/* conv_defs.svh */
`default_nettype none

`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

`define DWIDTH  16                  // Pixel and weight width.
`define LWIDTH  6                   // Line counters and image size.
`define MAXLINE 5                   // Kernel side.
`define MAXSIZE 32                  // Longest line held in a line memory.
`define QSHIFT  8                   // Fraction bits dropped at the output.

// Full products of two pixels need 2*DWIDTH bits, five more bits absorb the sum of 25 taps.
`define PWIDTH  (2*`DWIDTH+5)

`define NTAPS   (`MAXLINE*`MAXLINE) // Window elements.

`endif

`default_nettype wire

/* conv_mult.sv */
`include "conv_defs.svh"
`default_nettype none

module conv_mult (
  input  wire                    clk,
  input  wire                    xrst,
  input  wire conv_pkg::window_t window,
  input  wire                    win_valid,
  input  wire conv_pkg::kernel_t kernel,
  output conv_pkg::prod_t        prod
);

  function automatic conv_pkg::psum_t mul(input conv_pkg::pixel_t a,
                                          input conv_pkg::weight_t b);
    conv_pkg::psum_t ea;
    conv_pkg::psum_t eb;
    ea = a; // Sign extension.
    eb = b;
    return ea * eb;
  endfunction

  always_ff @(posedge clk) begin
    if (!xrst) begin
      prod <= '0;
    end else begin
      prod.valid <= win_valid;
      for (int k = 0; k < `NTAPS; k++) begin
        prod.p[k] <= mul(window.px[k], kernel.w[k]);
      end
    end
  end

endmodule

`default_nettype wire

/* conv_out.sv */
`include "conv_defs.svh"
`default_nettype none

module conv_out (
  input  wire                  clk,
  input  wire                  xrst,
  input  wire conv_pkg::acc_t  acc,
  input  wire conv_pkg::psum_t bias,
  output logic                 out_valid,
  output conv_pkg::pixel_t     out_data
);

  conv_pkg::psum_t  biased;
  conv_pkg::psum_t  shifted;
  conv_pkg::pixel_t pix_max;
  conv_pkg::psum_t  wide_max;

  assign biased   = acc.sum + bias;
  assign shifted  = biased >>> `QSHIFT; // Arithmetic, drops the fraction.
  assign pix_max  = {1'b0, {(`DWIDTH-1){1'b1}}};
  assign wide_max = pix_max;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= acc.valid;
      if (shifted[`PWIDTH-1]) begin
        out_data <= '0; // ReLU.
      end else if (shifted > wide_max) begin
        out_data <= pix_max;
      end else begin
        out_data <= shifted[`DWIDTH-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* conv_pkg.sv */
`include "conv_defs.svh"
`default_nettype none

package conv_pkg;

  typedef enum logic [1:0] {
    S_WAIT,
    S_CHARGE,
    S_ACTIVE
  } lb_state_e;

  typedef logic signed [`DWIDTH-1:0] pixel_t;
  typedef logic signed [`DWIDTH-1:0] weight_t;
  typedef logic signed [`PWIDTH-1:0] psum_t;

  // Row-major, element 0 is the top left.
  typedef struct packed {
    pixel_t [`NTAPS-1:0] px;
  } window_t;

  typedef struct packed {
    psum_t               bias;
    weight_t [`NTAPS-1:0] w;
  } kernel_t;

  typedef struct packed {
    logic               valid;
    psum_t [`NTAPS-1:0] p;
  } prod_t;

  typedef struct packed {
    logic  valid;
    psum_t sum;
  } acc_t;

endpackage

`default_nettype wire

/* conv_sum.sv */
`include "conv_defs.svh"
`default_nettype none

module conv_sum (
  input  wire                  clk,
  input  wire                  xrst,
  input  wire conv_pkg::prod_t prod,
  output conv_pkg::acc_t       acc
);

  conv_pkg::psum_t r_lvl1 [7];
  conv_pkg::psum_t r_lvl2 [2];
  logic            r_v1;
  logic            r_v2;

  // Six groups of four products, the last tap stands alone.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_v1 <= 1'b0;
      for (int g = 0; g < 7; g++) begin
        r_lvl1[g] <= '0;
      end
    end else begin
      r_v1 <= prod.valid;
      for (int g = 0; g < 6; g++) begin
        r_lvl1[g] <= prod.p[4*g] + prod.p[4*g+1] + prod.p[4*g+2] + prod.p[4*g+3];
      end
      r_lvl1[6] <= prod.p[`NTAPS-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_v2      <= 1'b0;
      r_lvl2[0] <= '0;
      r_lvl2[1] <= '0;
    end else begin
      r_v2      <= r_v1;
      r_lvl2[0] <= r_lvl1[0] + r_lvl1[1] + r_lvl1[2] + r_lvl1[3];
      r_lvl2[1] <= r_lvl1[4] + r_lvl1[5] + r_lvl1[6];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      acc <= '0;
    end else begin
      acc.valid <= r_v2;
      acc.sum   <= r_lvl2[0] + r_lvl2[1];
    end
  end

endmodule

`default_nettype wire

/* conv_top.sv */
`include "conv_defs.svh"
`default_nettype none

module conv_top (
  input  wire                   clk,
  input  wire                   xrst,
  input  wire                   wt_we,
  input  wire [4:0]             wt_addr,
  input  wire [`PWIDTH-1:0]     wt_data,
  input  wire                   buf_en,
  input  wire [`LWIDTH-1:0]     img_size,
  input  wire conv_pkg::pixel_t buf_input,
  output logic                  busy,
  output logic                  out_valid,
  output conv_pkg::pixel_t      out_data
);

  conv_pkg::kernel_t kernel;
  conv_pkg::window_t window;
  logic              win_valid;
  conv_pkg::prod_t   prod;
  conv_pkg::acc_t    acc;

  filter_store u_filter_store (
    .clk     (clk),
    .xrst    (xrst),
    .wt_we   (wt_we),
    .wt_addr (wt_addr),
    .wt_data (wt_data),
    .kernel  (kernel)
  );

  linebuf u_linebuf (
    .clk       (clk),
    .xrst      (xrst),
    .buf_en    (buf_en),
    .img_size  (img_size),
    .buf_input (buf_input),
    .busy      (busy),
    .window    (window),
    .win_valid (win_valid)
  );

  conv_mult u_conv_mult (
    .clk       (clk),
    .xrst      (xrst),
    .window    (window),
    .win_valid (win_valid),
    .kernel    (kernel),
    .prod      (prod)
  );

  conv_sum u_conv_sum (
    .clk  (clk),
    .xrst (xrst),
    .prod (prod),
    .acc  (acc)
  );

  conv_out u_conv_out (
    .clk       (clk),
    .xrst      (xrst),
    .acc       (acc),
    .bias      (kernel.bias),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

/* filter_store.sv */
`include "conv_defs.svh"
`default_nettype none

module filter_store (
  input  wire                clk,
  input  wire                xrst,
  input  wire                wt_we,
  input  wire [4:0]          wt_addr,
  input  wire [`PWIDTH-1:0]  wt_data,
  output conv_pkg::kernel_t  kernel
);

  logic is_weight;
  logic is_bias;

  assign is_weight = wt_addr < 5'd25;  // Taps 0 to 24, row-major.
  assign is_bias   = wt_addr == 5'd25;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      kernel <= '0;
    end else if (wt_we) begin
      if (is_weight) begin
        kernel.w[wt_addr] <= wt_data[`DWIDTH-1:0];
      end else if (is_bias) begin
        kernel.bias <= wt_data;  // Bias keeps the full accumulator width.
      end
    end
  end

endmodule

`default_nettype wire

/* linebuf.sv */
`include "conv_defs.svh"
`default_nettype none

module linebuf (
  input  wire                   clk,
  input  wire                   xrst,
  input  wire                   buf_en,
  input  wire [`LWIDTH-1:0]     img_size,
  input  wire conv_pkg::pixel_t buf_input,
  output logic                  busy,
  output conv_pkg::window_t     window,
  output logic                  win_valid
);

  conv_pkg::lb_state_e r_state;
  logic [`LWIDTH-1:0]  r_addr_count;
  logic [`LWIDTH-1:0]  r_line_count;
  logic [2:0]          r_mem_count;
  logic [2:0]          r_drain;

  // Control aligned with the registered memory read.
  logic                r_rd_act;
  logic [2:0]          r_rd_sel;
  logic [`LWIDTH-1:0]  r_rd_col;
  logic [`LWIDTH-1:0]  r_rd_line;

  logic                streaming;
  logic                last_col;
  logic                charge_end;
  logic                active_end;
  logic [`MAXLINE:0]   mem_we;
  conv_pkg::pixel_t    read_mem [`MAXLINE+1];

  // Memory that holds window row 'row' while line 'sel' is written.
  function automatic logic [2:0] row_mem(input logic [2:0] sel, input int row);
    logic [3:0] idx;
    idx = {1'b0, sel} + 4'(row + 1);
    if (idx > 4'd5) begin
      idx = idx - 4'd6;
    end
    return idx[2:0];
  endfunction

  assign streaming  = r_state != conv_pkg::S_WAIT;
  assign last_col   = r_addr_count == img_size - 1'b1;
  assign charge_end = r_line_count == `MAXLINE - 1 && last_col;
  assign active_end = r_line_count == img_size && last_col; // One flush line past the image.
  assign busy       = streaming || r_drain != 3'd0;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state <= conv_pkg::S_WAIT;
    end else begin
      case (r_state)
        conv_pkg::S_WAIT:   if (buf_en && !busy) r_state <= conv_pkg::S_CHARGE;
        conv_pkg::S_CHARGE: if (charge_end) r_state <= conv_pkg::S_ACTIVE;
        conv_pkg::S_ACTIVE: if (active_end) r_state <= conv_pkg::S_WAIT;
        default:            r_state <= conv_pkg::S_WAIT;
      endcase
    end
  end

  // Keeps busy up until the last window has left the arithmetic stages.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_drain <= '0;
    end else if (r_state == conv_pkg::S_ACTIVE && active_end) begin
      r_drain <= 3'd7; // Two window cycles plus five pipeline cycles.
    end else if (r_drain != 3'd0) begin
      r_drain <= r_drain - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_addr_count <= '0;
      r_line_count <= '0;
      r_mem_count  <= '0;
    end else if (!streaming) begin
      r_addr_count <= '0;
      r_line_count <= '0;
      r_mem_count  <= '0;
    end else if (last_col) begin
      r_addr_count <= '0;
      r_line_count <= r_line_count + 1'b1;
      if (r_mem_count == `MAXLINE) begin
        r_mem_count <= '0; // Six memories used round-robin.
      end else begin
        r_mem_count <= r_mem_count + 1'b1;
      end
    end else begin
      r_addr_count <= r_addr_count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_rd_act  <= 1'b0;
      r_rd_sel  <= '0;
      r_rd_col  <= '0;
      r_rd_line <= '0;
      win_valid <= 1'b0;
    end else begin
      r_rd_act  <= streaming;
      r_rd_sel  <= r_mem_count;
      r_rd_col  <= r_addr_count;
      r_rd_line <= r_line_count;
      // Rows L-5 to L-1 are read during line L, so L starts at five.
      win_valid <= r_rd_act && r_rd_line >= `MAXLINE && r_rd_col >= `MAXLINE - 1;
    end
  end

  // Column 4 takes the fresh read, the others shift left.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      window <= '0;
    end else begin
      for (int i = 0; i < `MAXLINE; i++) begin
        for (int j = 0; j < `MAXLINE - 1; j++) begin
          window.px[`MAXLINE*i+j] <= window.px[`MAXLINE*i+j+1];
        end
        window.px[`MAXLINE*i+`MAXLINE-1] <= read_mem[row_mem(r_rd_sel, i)];
      end
    end
  end

  for (genvar m = 0; m <= `MAXLINE; m++) begin : g_line
    assign mem_we[m] = streaming && r_mem_count == 3'(m);

    mem_sp u_mem (
      .clk        (clk),
      .mem_we     (mem_we[m]),
      .mem_addr   (r_addr_count),
      .write_data (buf_input),
      .read_data  (read_mem[m])
    );
  end

endmodule

`default_nettype wire

/* mem_sp.sv */
`include "conv_defs.svh"
`default_nettype none

module mem_sp (
  input  wire                   clk,
  input  wire                   mem_we,
  input  wire [`LWIDTH-1:0]     mem_addr,
  input  wire conv_pkg::pixel_t write_data,
  output conv_pkg::pixel_t      read_data
);

  conv_pkg::pixel_t             mem [`MAXSIZE];
  logic [$clog2(`MAXSIZE)-1:0]  addr;

  assign addr = mem_addr[$clog2(`MAXSIZE)-1:0]; // Image size never exceeds MAXSIZE.

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[addr] <= write_data;
    end
    read_data <= mem[addr]; // Returns the old word on a same-address write.
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
conv_pkg.sv
mem_sp.sv
filter_store.sv
linebuf.sv
conv_mult.sv
conv_sum.sv
conv_out.sv
conv_top.sv
tb_conv.sv
conv_asserts.sv

/* tb_conv.sv */
`include "conv_defs.svh"
`default_nettype none

module tb_conv;

  typedef enum logic [1:0] {PIX_RANDOM, PIX_RAMP, PIX_LARGE} pix_mode_e;
  typedef enum logic [1:0] {KRN_ZERO, KRN_SMALL, KRN_ONES, KRN_NEG} krn_mode_e;
  typedef enum logic [1:0] {EXP_MODEL, EXP_ZERO, EXP_MAX} exp_kind_e;

  typedef struct packed {
    logic [`LWIDTH-1:0] size;
    pix_mode_e          pix_mode;
    krn_mode_e          krn_mode;
    logic signed [31:0] bias;
    exp_kind_e          exp_kind;
  } frame_row_t;

  localparam int CLK_PERIOD = 20;
  localparam int NFRAMES    = 8;
  localparam int PIX_MAX    = (1 << (`DWIDTH - 1)) - 1;

  // Size, pixels, kernel, bias, and what every output must also equal.
  localparam frame_row_t FRAMES [NFRAMES] = '{
    '{6'd6,  PIX_RANDOM, KRN_ZERO,  32'sd0,    EXP_ZERO},
    '{6'd6,  PIX_RANDOM, KRN_SMALL, 32'sd100,  EXP_MODEL},
    '{6'd8,  PIX_RANDOM, KRN_SMALL, -32'sd500, EXP_MODEL},
    '{6'd12, PIX_RANDOM, KRN_SMALL, 32'sd0,    EXP_MODEL},
    '{6'd8,  PIX_RAMP,   KRN_NEG,   32'sd0,    EXP_ZERO},
    '{6'd7,  PIX_LARGE,  KRN_ONES,  32'sd0,    EXP_MAX},
    '{6'd10, PIX_RAMP,   KRN_SMALL, 32'sd37,   EXP_MODEL},
    '{6'd32, PIX_RANDOM, KRN_SMALL, 32'sd64,   EXP_MODEL}
  };

  logic               clk = 1'b0;
  logic               xrst;
  logic               wt_we;
  logic [4:0]         wt_addr;
  logic [`PWIDTH-1:0] wt_data;
  logic               buf_en;
  logic [`LWIDTH-1:0] img_size;
  conv_pkg::pixel_t   buf_input;
  logic               busy;
  logic               out_valid;
  conv_pkg::pixel_t   out_data;

  int        img [`MAXSIZE*`MAXSIZE];
  int        wt [`NTAPS];
  int        bias;
  longint    exp_q [$];
  exp_kind_e cur_exp;
  int        out_count;
  int        error_count;
  int        cycle_count = 0;
  int        timeout_cycles;

  conv_top u_conv_top (
    .clk       (clk),
    .xrst      (xrst),
    .wt_we     (wt_we),
    .wt_addr   (wt_addr),
    .wt_data   (wt_data),
    .buf_en    (buf_en),
    .img_size  (img_size),
    .buf_input (buf_input),
    .busy      (busy),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input longint actual, input longint expected);
    if (actual != expected) begin
      error_count++;
      $display("mismatch at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
      $display("Test failures found");
      $fatal(1, "stopped at first error");
    end
  endtask

  function automatic int timeout_limit();
    int total;
    total = 0;
    for (int f = 0; f < NFRAMES; f++) begin
      total += (int'(FRAMES[f].size) + 2) * int'(FRAMES[f].size) + 100;
    end
    return total;
  endfunction

  // Bias added before the shift, then ReLU and clamp to the pixel range.
  function automatic longint model_pixel(input int n, input int r, input int c);
    longint acc;
    acc = bias;
    for (int i = 0; i < `MAXLINE; i++) begin
      for (int j = 0; j < `MAXLINE; j++) begin
        acc += longint'(img[(r + i) * n + c + j]) * longint'(wt[`MAXLINE * i + j]);
      end
    end
    acc = acc >>> `QSHIFT;
    if (acc < 0) return 0;
    if (acc > PIX_MAX) return PIX_MAX;
    return acc;
  endfunction

  task automatic prepare_frame(input frame_row_t row);
    int n;
    n = int'(row.size);
    for (int p = 0; p < n * n; p++) begin
      case (row.pix_mode)
        PIX_RANDOM: img[p] = int'($urandom % 2048) - 1024;
        PIX_RAMP:   img[p] = p;
        default:    img[p] = 32000 + int'($urandom % 768);
      endcase
    end
    for (int k = 0; k < `NTAPS; k++) begin
      case (row.krn_mode)
        KRN_ZERO:  wt[k] = 0;
        KRN_SMALL: wt[k] = int'($urandom % 128) - 64;
        KRN_ONES:  wt[k] = 1 << `QSHIFT; // 1.0 in output fixed point.
        default:   wt[k] = -3 - int'($urandom % 8);
      endcase
    end
    bias = row.bias;
  endtask

  task automatic load_kernel();
    for (int a = 0; a <= `NTAPS; a++) begin
      @(negedge clk);
      wt_we   = 1'b1;
      wt_addr = 5'(a);
      wt_data = (a < `NTAPS) ? `PWIDTH'(wt[a]) : `PWIDTH'(bias); // Address 25 is the bias.
    end
    @(negedge clk);
    wt_we = 1'b0;
  endtask

  task automatic stream_frame(input int n);
    @(negedge clk);
    buf_en = 1'b1;
    for (int p = 0; p < n * n; p++) begin
      @(negedge clk);
      buf_en    = (p == 5 * n + 1); // Stray strobe in mid-frame.
      buf_input = conv_pkg::pixel_t'(img[p]);
    end
    @(negedge clk);
    buf_en    = 1'b0;
    buf_input = '0;
    repeat (n) @(negedge clk);
    buf_en = 1'b1; // Stray strobe after the flush line, while the last windows drain.
    @(negedge clk);
    buf_en = 1'b0;
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk);
    end while (busy);
  endtask

  task automatic run_frame(input frame_row_t row);
    int n;
    int windows;
    n       = int'(row.size);
    windows = (n - 4) * (n - 4);
    prepare_frame(row);
    load_kernel();
    for (int r = 0; r <= n - `MAXLINE; r++) begin
      for (int c = 0; c <= n - `MAXLINE; c++) begin
        exp_q.push_back(model_pixel(n, r, c));
      end
    end
    cur_exp   = row.exp_kind;
    out_count = 0;
    img_size  = row.size;
    stream_frame(n);
    wait_idle();
    check_value("out_count", out_count, windows);
    check_value("pending_outputs", exp_q.size(), 0);
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d clock cycles", timeout_cycles);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  // Outputs change on the rising edge and are read on the falling edge.
  always @(negedge clk) begin
    if (xrst && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("unexpected output at %0t with no window left to expect", $time);
        $display("Test failures found");
        $fatal(1, "extra output");
      end else begin
        check_value("out_data", out_data, exp_q.pop_front());
        if (cur_exp == EXP_ZERO) check_value("out_data", out_data, 0);
        if (cur_exp == EXP_MAX) check_value("out_data", out_data, PIX_MAX);
        out_count++;
      end
    end
  end

  initial begin
    void'($urandom(83));
    xrst           = 1'b0;
    wt_we          = 1'b0;
    wt_addr        = '0;
    wt_data        = '0;
    buf_en         = 1'b0;
    img_size       = `LWIDTH'(6);
    buf_input      = '0;
    error_count    = 0;
    out_count      = 0;
    cur_exp        = EXP_MODEL;
    timeout_cycles = timeout_limit();
    repeat (2) @(negedge clk);
    xrst = 1'b1;
    check_value("busy", busy, 0);
    check_value("out_valid", out_valid, 0);
    for (int f = 0; f < NFRAMES; f++) begin
      run_frame(FRAMES[f]);
    end
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
